//--- tb.f
source/div_types_pkg.sv
source/div_ctrl_pkg.sv
source/div_if.sv
source/div_subshift.sv
source/div_subshift_frac.sv
source/frac_div_top.sv
testbench/frac_div_assert.sv
testbench/frac_div_tb.sv

//--- testbench/frac_div_tb.sv
`timescale 1ns/1ps
`default_nettype none

module frac_div_tb;

   import div_types_pkg::*;

   logic  clk = 1'b0;
   logic  reset;
   logic  start;
   logic  done;
   data_t dividend;
   data_t divisor;
   data_t quotient;
   data_t remainder;

   int    errors = 0;
   int    checks = 0;
   int    cycle_cnt = 0;
   int    issued = 0;
   int    checked = 0;
   acc_t  model_acc = '0;
   data_t last_quotient;
   longint quotient_sum;

   data_t exp_quo[$];
   data_t exp_rem[$];
   int    start_cycle[$];

   frac_div_top frac_div_top_i (
      .clk_i      (clk),
      .reset_i    (reset),
      .start_i    (start),
      .done_o     (done),
      .dividend_i (dividend),
      .divisor_i  (divisor),
      .quotient_o (quotient),
      .remainder_o(remainder)
   );

   always #20 clk = ~clk;

   always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

   // Integer division plus the residue carry rule.
   function automatic void reference_divide(input data_t a, input data_t b, input acc_t acc_in,
                                            output data_t q, output data_t r, output acc_t acc_out);
      acc_t sum;
      if (b == '0) begin
         q       = '1;
         r       = a;
         acc_out = acc_in;
      end else begin
         q   = a / b;
         r   = a % b;
         sum = acc_in + acc_t'(r);
         if (sum >= acc_t'(b)) begin
            acc_out = sum - acc_t'(b);
            q       = q + 1;
         end else begin
            acc_out = sum;
         end
      end
   endfunction

   task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAIL %0t: %s is %0h, expected %0h", $time, name, got, exp);
      end
   endtask

   task automatic run_division(input data_t a, input data_t b, input bit busy_start);
      data_t q;
      data_t r;
      acc_t  acc_next;
      int    waited;
      reference_divide(a, b, model_acc, q, r, acc_next);
      model_acc = acc_next;
      @(negedge clk);
      start    = 1'b1;
      dividend = a;
      divisor  = b;
      exp_quo.push_back(q);
      exp_rem.push_back(r);
      start_cycle.push_back(cycle_cnt + 1);  // Value after the sampling edge.
      issued++;
      @(negedge clk);
      start = 1'b0;
      if (busy_start) begin
         repeat (5) @(negedge clk);
         start    = 1'b1;  // Lands in FRAC_RUN.
         dividend = ~a;
         divisor  = b + 1;
         @(negedge clk);
         start = 1'b0;
      end
      waited = 0;
      while (checked != issued && waited < 200) begin
         @(negedge clk);
         waited++;
      end
      if (checked != issued) begin
         errors++;
         $display("Timeout: result of division %0d was never checked", issued);
      end
   endtask

   // Compares each result as soon as done_o rises.
   initial begin : compare_results
      data_t q;
      data_t r;
      int    c0;
      int    waited;
      forever begin
         waited = 0;
         while (exp_quo.size() == 0 && waited < 2000) begin
            @(negedge clk);
            waited++;
         end
         if (exp_quo.size() == 0) begin
            errors++;
            $display("Timeout: no division was started for 2000 cycles");
         end else begin
            q  = exp_quo.pop_front();
            r  = exp_rem.pop_front();
            c0 = start_cycle.pop_front();
            waited = 0;
            while (!(cycle_cnt >= c0 && done) && waited < 100) begin
               @(negedge clk);
               waited++;
            end
            if (!(cycle_cnt >= c0 && done)) begin
               errors++;
               $display("Timeout: done_o did not rise within 100 cycles of a start");
            end else begin
               check_value("quotient", quotient, q);
               check_value("remainder", remainder, r);
               check_value("latency", cycle_cnt - c0, DATA_W + 2);
               last_quotient = quotient;
            end
            checked++;
         end
      end
   end

   initial begin
      data_t a;
      data_t b;
      void'($urandom(83439));
      reset    = 1'b1;
      start    = 1'b0;
      dividend = '0;
      divisor  = '0;
      repeat (5) @(negedge clk);
      reset = 1'b0;

      repeat (10) begin
         @(negedge clk);
         check_value("done_o before first start", done, 1'b0);
      end

      run_division(32'd100, 32'd10, 1'b0);
      run_division(32'd0, 32'd7, 1'b0);
      run_division(32'd196605, 32'd3, 1'b0);
      run_division(32'd42, 32'd42, 1'b0);
      run_division(32'hFFFF_FFFF, 32'h0000_FFFF, 1'b0);

      // Mean quotient converges on 1000/7.
      quotient_sum = 0;
      repeat (60) begin
         run_division(32'd1000, 32'd7, 1'b0);
         quotient_sum += last_quotient;
      end
      check_value("quotient sum", quotient_sum, (60 * 1000) / 7);

      run_division(32'd123456, 32'd0, 1'b0);
      run_division(32'hFFFF_FFFF, 32'd0, 1'b0);
      run_division(32'd1000, 32'd7, 1'b0);  // Residue untouched by the zero divisor.

      run_division(32'd500000, 32'd13, 1'b1);
      repeat (10) begin
         @(negedge clk);
         check_value("done_o held after ignored start", done, 1'b1);
      end

      repeat (200) begin
         a = $urandom;
         b = $urandom >> ($urandom % 32);
         if (b == '0) begin
            b = 32'd1;
         end
         run_division(a, b, 1'b0);
      end

      errors += frac_div_top_i.frac_i.frac_div_assert_i.failures;
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- testbench/frac_div_assert.sv
`timescale 1ns/1ps
`default_nettype none

module frac_div_assert (
   input logic                      clk_i,
   input logic                      reset_i,
   input logic                      start_i,
   input logic                      done_i,
   input div_ctrl_pkg::frac_state_t state_i,
   input div_types_pkg::acc_t       acc_i,
   input div_types_pkg::data_t      latched_divisor_i,
   input div_types_pkg::data_t      quotient_i,
   input div_types_pkg::data_t      remainder_i
);

   import div_types_pkg::*;
   import div_ctrl_pkg::*;

   logic accept;
   int   failures = 0;

   assign accept = start_i && (state_i == FRAC_IDLE || state_i == FRAC_HOLD);

   // A held result stays put until the next start.
   result_held: assert property (
      @(posedge clk_i) disable iff (reset_i)
      (done_i && !start_i) |=> (done_i && $stable(quotient_i) && $stable(remainder_i))
   ) else begin
      failures++;
      $error("held result changed while no start was given");
   end

   // A residue already below the divisor stays below it after the update.
   acc_below_divisor: assert property (
      @(posedge clk_i) disable iff (reset_i)
      (state_i == FRAC_ADJUST && latched_divisor_i != '0 && acc_i < acc_t'(latched_divisor_i))
         |=> (acc_i < acc_t'(latched_divisor_i))
   ) else begin
      failures++;
      $error("accumulator not below the divisor after the residue update");
   end

   done_latency: assert property (
      @(posedge clk_i) disable iff (reset_i)
      accept |=> (!done_i) [*(DATA_W + 2)] ##1 done_i
   ) else begin
      failures++;
      $error("done_o did not rise DATA_W+2 cycles after an accepted start");
   end

endmodule

bind div_subshift_frac frac_div_assert frac_div_assert_i (
   .clk_i            (clk_i),
   .reset_i          (reset_i),
   .start_i          (start_i),
   .done_i           (done_o),
   .state_i          (state_q),
   .acc_i            (acc_q),
   .latched_divisor_i(divisor_q),
   .quotient_i       (quotient_o),
   .remainder_i      (remainder_o)
);

`default_nettype wire

//--- source/frac_div_top.sv
`timescale 1ns/1ps
`default_nettype none

module frac_div_top (
   input  logic                 clk_i,
   input  logic                 reset_i,
   input  logic                 start_i,
   output logic                 done_o,
   input  div_types_pkg::data_t dividend_i,
   input  div_types_pkg::data_t divisor_i,
   output div_types_pkg::data_t quotient_o,
   output div_types_pkg::data_t remainder_o
);

   div_if div_bus ();

   // Residue accumulation and quotient correction.
   div_subshift_frac frac_i (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .start_i    (start_i),
      .done_o     (done_o),
      .dividend_i (dividend_i),
      .divisor_i  (divisor_i),
      .quotient_o (quotient_o),
      .remainder_o(remainder_o),
      .div        (div_bus.requester)
   );

   // Shift-subtract core.
   div_subshift core_i (
      .clk_i  (clk_i),
      .reset_i(reset_i),
      .div    (div_bus.divider)
   );

endmodule

`default_nettype wire

//--- source/div_subshift_frac.sv
`timescale 1ns/1ps
`default_nettype none

module div_subshift_frac (
   input  logic                 clk_i,
   input  logic                 reset_i,
   input  logic                 start_i,
   output logic                 done_o,
   input  div_types_pkg::data_t dividend_i,
   input  div_types_pkg::data_t divisor_i,
   output div_types_pkg::data_t quotient_o,
   output div_types_pkg::data_t remainder_o,
   div_if.requester             div
);

   import div_types_pkg::*;
   import div_ctrl_pkg::*;

   frac_state_t state_q;
   frac_state_t state_d;

   acc_t  acc_q;      // Residue accumulator.
   acc_t  acc_sum;
   acc_t  acc_d;
   logic  incr_q;     // Quotient correction of the last division.
   logic  incr_d;
   data_t divisor_q;  // Same divisor the core latched.
   logic  accept;

   // New work only when idle or holding a result.
   assign accept = start_i && (state_q == FRAC_IDLE || state_q == FRAC_HOLD);

   assign div.start    = accept;
   assign div.dividend = dividend_i;
   assign div.divisor  = divisor_i;

   always_comb begin
      state_d = state_q;
      case (state_q)
         FRAC_IDLE: begin
            if (accept) begin
               state_d = FRAC_RUN;
            end
         end
         FRAC_RUN: begin
            if (div.done) begin
               state_d = FRAC_ADJUST;
            end
         end
         FRAC_ADJUST: begin
            state_d = FRAC_HOLD;
         end
         FRAC_HOLD: begin
            if (accept) begin
               state_d = FRAC_RUN;
            end
         end
         default: begin
            state_d = FRAC_IDLE;
         end
      endcase
   end

   assign acc_sum = acc_q + acc_t'(div.remainder);

   always_comb begin
      acc_d  = acc_q;
      incr_d = 1'b0;
      if (divisor_q != '0) begin
         if (acc_sum >= acc_t'(divisor_q)) begin
            acc_d  = acc_sum - acc_t'(divisor_q);  // Carry one into the quotient.
            incr_d = 1'b1;
         end else begin
            acc_d = acc_sum;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         state_q <= FRAC_IDLE;
         acc_q   <= '0;
         incr_q  <= 1'b0;
      end else begin
         state_q <= state_d;
         if (state_q == FRAC_ADJUST) begin
            acc_q  <= acc_d;  // Once per division.
            incr_q <= incr_d;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (accept) begin
         divisor_q <= divisor_i;
      end
   end

   assign done_o      = (state_q == FRAC_HOLD);
   assign quotient_o  = div.quotient + data_t'(incr_q);
   assign remainder_o = div.remainder;

endmodule

`default_nettype wire

//--- source/div_subshift.sv
`timescale 1ns/1ps
`default_nettype none

module div_subshift (
   input  logic   clk_i,
   input  logic   reset_i,
   div_if.divider div
);

   import div_types_pkg::*;
   import div_ctrl_pkg::*;

   core_state_t state_q;
   core_state_t state_d;
   cnt_t        cnt_q;

   data_t dvs_q;  // Divisor latched at start.
   data_t rem_q;  // Partial remainder.
   data_t quo_q;  // Dividend bits shift out, quotient bits shift in.

   acc_t trial;
   acc_t diff;
   logic q_bit;
   logic last_step;
   logic accept;

   // A start during the shift phase is dropped.
   assign accept = div.start && (state_q != CORE_SHIFT);

   assign last_step = (cnt_q == cnt_t'(DATA_W - 1));

   // Next dividend bit joins the partial remainder.
   assign trial = {rem_q, quo_q[DATA_W-1]};
   assign diff  = trial - {1'b0, dvs_q};
   assign q_bit = (trial >= {1'b0, dvs_q});

   always_comb begin
      state_d = state_q;
      case (state_q)
         CORE_IDLE: begin
            if (accept) begin
               state_d = CORE_SHIFT;
            end
         end
         CORE_SHIFT: begin
            if (last_step) begin
               state_d = CORE_DONE;
            end
         end
         CORE_DONE: begin
            if (accept) begin
               state_d = CORE_SHIFT;
            end
         end
         default: begin
            state_d = CORE_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         state_q <= CORE_IDLE;
         cnt_q   <= '0;
      end else begin
         state_q <= state_d;
         if (state_q == CORE_SHIFT && !last_step) begin
            cnt_q <= cnt_q + 1'b1;
         end else begin
            cnt_q <= '0;  // Ready for the next run.
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (accept) begin
         dvs_q <= div.divisor;
         rem_q <= '0;
         quo_q <= div.dividend;
      end else if (state_q == CORE_SHIFT) begin
         if (q_bit) begin
            rem_q <= diff[DATA_W-1:0];   // Restore not needed.
         end else begin
            rem_q <= trial[DATA_W-1:0];
         end
         quo_q <= {quo_q[DATA_W-2:0], q_bit};
      end
   end

   // With a zero divisor every step subtracts nothing, so all ones come out.
   assign div.done      = (state_q == CORE_DONE);
   assign div.quotient  = quo_q;
   assign div.remainder = rem_q;

endmodule

`default_nettype wire

//--- source/div_if.sv
`timescale 1ns/1ps
`default_nettype none

interface div_if;

   import div_types_pkg::*;

   logic  start;      // One-cycle request pulse.
   logic  done;       // Level, high while the result is valid.
   data_t dividend;
   data_t divisor;
   data_t quotient;
   data_t remainder;

   modport requester (
      output start,
      output dividend,
      output divisor,
      input  done,
      input  quotient,
      input  remainder
   );

   modport divider (
      input  start,
      input  dividend,
      input  divisor,
      output done,
      output quotient,
      output remainder
   );

endinterface

`default_nettype wire

//--- source/div_ctrl_pkg.sv
`default_nettype none

package div_ctrl_pkg;

   // Divider core FSM.
   typedef enum logic [1:0] {
      CORE_IDLE  = 2'd0,  // No result yet.
      CORE_SHIFT = 2'd1,  // One quotient bit per cycle.
      CORE_DONE  = 2'd2   // Result held until next start.
   } core_state_t;

   // Fractional stage FSM.
   typedef enum logic [1:0] {
      FRAC_IDLE   = 2'd0,
      FRAC_RUN    = 2'd1,  // Core busy.
      FRAC_ADJUST = 2'd2,  // Residue update.
      FRAC_HOLD   = 2'd3   // Result presented.
   } frac_state_t;

endpackage

`default_nettype wire

//--- source/div_types_pkg.sv
`default_nettype none

package div_types_pkg;

   // Operand width of the whole divider.
   localparam int DATA_W = 32;

   // Wide enough to count DATA_W shift steps.
   localparam int CNT_W = 6;

   // Dividend, divisor, quotient and remainder.
   typedef logic [DATA_W-1:0] data_t;

   // Residue accumulator, one spare bit for the sum of two remainders.
   typedef logic [DATA_W:0] acc_t;

   // Shift step counter of the core.
   typedef logic [CNT_W-1:0] cnt_t;

endpackage

`default_nettype wire
